/* hw/lsu_defines.svh */
// Width and depth macros shared by the store path
// Data, address and ROB tag widths, queue depths and the cache geometry

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Core data path widths
`define LSU_DATA_WIDTH  32
`define LSU_ADDR_WIDTH  32
`define LSU_TAG_WIDTH   6
`define LSU_SQ_DEPTH    8
`define LSU_MSHQ_DEPTH  2

// Data cache geometry, two ways of sixteen 32-byte lines
`define DC_LINE_WIDTH   5
`define DC_INDEX_WIDTH  4
`define DC_WAY_WIDTH    1
`define DC_TAG_WIDTH    23

`endif

/* hw/lsu_pkg.sv */
// Store op types
// Store function, data word, byte address, ROB tag and store queue slot index

`include "lsu_defines.svh"

package lsu_pkg;

    // Kind of store, which selects how many low bytes are written
    typedef enum logic [1:0] {
        SB,
        SH,
        SW
    } lsu_func_t;

    typedef logic [`LSU_DATA_WIDTH-1:0]         data_t;
    typedef logic [`LSU_ADDR_WIDTH-1:0]         addr_t;
    typedef logic [`LSU_TAG_WIDTH-1:0]          rob_tag_t;
    typedef logic [$clog2(`LSU_SQ_DEPTH)-1:0]   sq_idx_t;

endpackage

/* hw/dc_pkg.sv */
// Data cache geometry types
// Set index, line tag, way, word offset and the data array word address

`include "lsu_defines.svh"

package dc_pkg;

    typedef logic [`DC_INDEX_WIDTH-1:0]   dc_index_t;
    typedef logic [`DC_TAG_WIDTH-1:0]     dc_tag_t;
    typedef logic [`DC_WAY_WIDTH-1:0]     dc_way_t;

    // Word inside a line, byte offset bits 1:0 are dropped
    typedef logic [`DC_LINE_WIDTH-3:0]    dc_word_t;

    // Data array address is set, then way, then word
    typedef logic [`DC_INDEX_WIDTH+`DC_WAY_WIDTH+`DC_LINE_WIDTH-3:0] dc_array_addr_t;

endpackage

/* hw/lsu_store_id.sv */
// Store issue stage
// Effective address adder and the register that feeds store queue allocation

`timescale 1ns/1ps

module lsu_store_id
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_flush,

    // Store from the reservation station
    input  logic       i_issue_en,
    input  addr_t      i_issue_base,
    input  addr_t      i_issue_offset,
    input  data_t      i_issue_data,
    input  rob_tag_t   i_issue_tag,
    input  lsu_func_t  i_issue_func,

    // Registered store towards the store queue
    output logic       o_alloc_en,
    output addr_t      o_alloc_addr,
    output data_t      o_alloc_data,
    output rob_tag_t   o_alloc_tag,
    output lsu_func_t  o_alloc_func
);

    addr_t eff_addr;

    // Effective address is base plus offset, carry out is dropped
    assign eff_addr = i_issue_base + i_issue_offset;

    // Valid bit of the stage, a flush throws the held store away
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_alloc_en <= 1'b0;
        end else if (i_flush) begin
            o_alloc_en <= 1'b0;
        end else begin
            o_alloc_en <= i_issue_en;
        end
    end

    // Payload only moves when a store is issued
    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_alloc_addr <= eff_addr;
            o_alloc_data <= i_issue_data;
            o_alloc_tag  <= i_issue_tag;
            o_alloc_func <= i_issue_func;
        end
    end

endmodule

/* hw/lsu_sq.sv */
// Store queue
// Slot array with allocation into the lowest free slot and retire by ROB tag
// Cache lookup of the retiring store, byte merge, cache write and miss push

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_sq
    import lsu_pkg::*;
    import dc_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,
    input  logic            i_flush,

    // Allocation from the issue stage
    input  logic            i_alloc_en,
    input  addr_t           i_alloc_addr,
    input  data_t           i_alloc_data,
    input  rob_tag_t        i_alloc_tag,
    input  lsu_func_t       i_alloc_func,

    // Retire request from the ROB
    input  logic            i_rob_retire_en,
    input  rob_tag_t        i_rob_retire_tag,

    // Lookup result from the data cache and miss queue state
    input  logic            i_dc_hit,
    input  dc_way_t         i_dc_way,
    input  data_t           i_dc_data,
    input  logic            i_mshq_full,

    output logic            o_sq_full,
    output logic            o_rob_retire_stall,

    // Cache lookup and store write
    output dc_index_t       o_dc_index,
    output dc_tag_t         o_dc_tag,
    output logic            o_dc_write_en,
    output dc_array_addr_t  o_dc_write_addr,
    output data_t           o_dc_write_data,

    // Retiring store, shared by the miss queue and the load queue
    output logic            o_miss_push,
    output addr_t           o_retire_addr,
    output lsu_func_t       o_retire_func,
    output logic            o_retire_hit,
    output logic            o_retire_en,
    output data_t           o_retire_data
);

    // Slot payload has no reset, the valid vector says what is live
    addr_t     slot_addr [`LSU_SQ_DEPTH];
    data_t     slot_data [`LSU_SQ_DEPTH];
    rob_tag_t  slot_tag  [`LSU_SQ_DEPTH];
    lsu_func_t slot_func [`LSU_SQ_DEPTH];

    logic [`LSU_SQ_DEPTH-1:0] slot_valid;
    logic [`LSU_SQ_DEPTH-1:0] empty;
    logic [`LSU_SQ_DEPTH-1:0] alloc_sel;
    logic [`LSU_SQ_DEPTH-1:0] retire_sel;

    sq_idx_t retire_slot;
    logic    allocating;
    logic    retiring;
    data_t   old_word;
    addr_t   ret_addr;
    data_t   ret_data;

    assign empty = ~slot_valid;

    // Lowest set bit of the empty vector picks the allocation slot
    assign alloc_sel  = empty & (~empty + 1'b1);
    assign allocating = i_alloc_en && (|empty);

    // Full leaves room for the store that still sits in the issue stage
    // Clearing the lowest bit leaves zero when at most one slot is empty
    assign o_sq_full = ((empty & (empty - 1'b1)) == '0);

    // Only one live slot may carry the retiring tag
    always_comb begin
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            retire_sel[i] = slot_valid[i] && (slot_tag[i] == i_rob_retire_tag);
        end
    end

    // One-hot to binary, OR of the indices of the set bits
    always_comb begin
        retire_slot = '0;
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            if (retire_sel[i]) begin
                retire_slot = retire_slot | sq_idx_t'(i);
            end
        end
    end

    assign ret_addr = slot_addr[retire_slot];
    assign ret_data = slot_data[retire_slot];

    // Split the store address into the cache tag, set and word fields
    assign o_dc_index = ret_addr[`DC_INDEX_WIDTH+`DC_LINE_WIDTH-1:`DC_LINE_WIDTH];
    assign o_dc_tag   = ret_addr[`LSU_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];

    // A miss needs a free miss queue entry, otherwise the ROB is held
    assign o_rob_retire_stall = i_rob_retire_en && !i_dc_hit && i_mshq_full;
    assign retiring           = i_rob_retire_en && !o_rob_retire_stall;

    // The cache word counts as zero when the line is not present
    assign old_word = i_dc_hit ? i_dc_data : '0;

    // Byte merge, the store replaces only its low bytes
    always_comb begin
        case (slot_func[retire_slot])
            SB:      o_retire_data = {old_word[`LSU_DATA_WIDTH-1:8], ret_data[7:0]};
            SH:      o_retire_data = {old_word[`LSU_DATA_WIDTH-1:16], ret_data[15:0]};
            default: o_retire_data = ret_data;
        endcase
    end

    assign o_dc_write_en   = retiring && i_dc_hit;
    assign o_dc_write_addr = {o_dc_index, i_dc_way, ret_addr[`DC_LINE_WIDTH-1:2]};
    assign o_dc_write_data = o_retire_data;

    assign o_miss_push   = retiring && !i_dc_hit;
    assign o_retire_en   = retiring;
    assign o_retire_addr = ret_addr;
    assign o_retire_func = slot_func[retire_slot];
    assign o_retire_hit  = i_dc_hit;

    // Valid bits are set on allocation and cleared on retire or flush
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retiring && retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Payload of a newly allocated store
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_addr[i] <= i_alloc_addr;
                slot_data[i] <= i_alloc_data;
                slot_tag[i]  <= i_alloc_tag;
                slot_func[i] <= i_alloc_func;
            end
        end
    end

endmodule

/* hw/dc_store_array.sv */
// Two-way data cache arrays
// Per-way valid and tag per set, word data array, combinational lookup
// Fill port for whole-word refills and the store write port

`timescale 1ns/1ps
`include "lsu_defines.svh"

module dc_store_array
    import lsu_pkg::*;
    import dc_pkg::*;
(
    input  logic            clk,
    input  logic            n_rst,

    // Lookup of the retiring store
    input  dc_index_t       i_lookup_index,
    input  dc_tag_t         i_lookup_tag,
    input  dc_word_t        i_lookup_word,

    // Fill port
    input  logic            i_fill_en,
    input  addr_t           i_fill_addr,
    input  dc_way_t         i_fill_way,
    input  data_t           i_fill_data,

    // Store write port
    input  logic            i_write_en,
    input  dc_array_addr_t  i_write_addr,
    input  data_t           i_write_data,

    output logic            o_hit,
    output dc_way_t         o_way,
    output data_t           o_data
);

    localparam int NUM_SETS  = 1 << `DC_INDEX_WIDTH;
    localparam int NUM_WAYS  = 1 << `DC_WAY_WIDTH;
    localparam int NUM_WORDS = 1 << $bits(dc_array_addr_t);

    logic    line_valid [NUM_SETS][NUM_WAYS];
    dc_tag_t line_tag   [NUM_SETS][NUM_WAYS];
    data_t   data_mem   [NUM_WORDS];

    logic [NUM_WAYS-1:0] way_hit;
    dc_index_t           fill_index;
    dc_tag_t             fill_tag;
    dc_array_addr_t      fill_word_addr;

    // Compare the tags of both ways of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = line_valid[i_lookup_index][w] &&
                         (line_tag[i_lookup_index][w] == i_lookup_tag);
        end
    end

    assign o_hit  = |way_hit;
    assign o_way  = dc_way_t'(way_hit[1]);
    assign o_data = data_mem[{i_lookup_index, o_way, i_lookup_word}];

    // Fill address uses the same split as the store address
    assign fill_index     = i_fill_addr[`DC_INDEX_WIDTH+`DC_LINE_WIDTH-1:`DC_LINE_WIDTH];
    assign fill_tag       = i_fill_addr[`LSU_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign fill_word_addr = {fill_index, i_fill_way, i_fill_addr[`DC_LINE_WIDTH-1:2]};

    // A fill makes its line valid under the new tag
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    line_valid[s][w] <= 1'b0;
                end
            end
        end else if (i_fill_en) begin
            line_valid[fill_index][i_fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            line_tag[fill_index][i_fill_way] <= fill_tag;
        end
    end

    // Fill wins over a store to the same word
    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            data_mem[fill_word_addr] <= i_fill_data;
        end
        if (i_write_en && !(i_fill_en && (fill_word_addr == i_write_addr))) begin
            data_mem[i_write_addr] <= i_write_data;
        end
    end

endmodule

/* hw/lsu_mshq.sv */
// Miss queue for retired stores
// Circular FIFO with an occupancy count, the head entry drives the memory port

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_mshq
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,

    // Missed store from the store queue
    input  logic       i_push,
    input  addr_t      i_push_addr,
    input  data_t      i_push_data,
    input  lsu_func_t  i_push_func,
    output logic       o_full,

    // Memory write port
    input  logic       i_mem_ready,
    output logic       o_mem_wr_en,
    output addr_t      o_mem_addr,
    output data_t      o_mem_data,
    output lsu_func_t  o_mem_func
);

    localparam int PTR_W = $clog2(`LSU_MSHQ_DEPTH);
    localparam int CNT_W = $clog2(`LSU_MSHQ_DEPTH + 1);

    addr_t     q_addr [`LSU_MSHQ_DEPTH];
    data_t     q_data [`LSU_MSHQ_DEPTH];
    lsu_func_t q_func [`LSU_MSHQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign o_full      = (count == CNT_W'(`LSU_MSHQ_DEPTH));
    assign o_mem_wr_en = (count != '0);
    assign pop         = o_mem_wr_en && i_mem_ready;

    // The head stays on the port until memory takes it
    assign o_mem_addr = q_addr[head];
    assign o_mem_data = q_data[head];
    assign o_mem_func = q_func[head];

    // Pointers wrap naturally with a power of two depth
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // A push and a pop in one cycle leave the count alone
            if (i_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !i_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            q_addr[tail] <= i_push_addr;
            q_data[tail] <= i_push_data;
            q_func[tail] <= i_push_func;
        end
    end

endmodule

/* hw/lsu_store_path.sv */
// Store path top level
// Issue stage, store queue, two-way data cache arrays and miss queue

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_path
    import lsu_pkg::*;
    import dc_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_flush,

    // Issue port
    input  logic       i_issue_en,
    input  addr_t      i_issue_base,
    input  addr_t      i_issue_offset,
    input  data_t      i_issue_data,
    input  rob_tag_t   i_issue_tag,
    input  lsu_func_t  i_issue_func,
    output logic       o_sq_full,

    // ROB retire port
    input  logic       i_rob_retire_en,
    input  rob_tag_t   i_rob_retire_tag,
    output logic       o_rob_retire_stall,

    // Retiring store for the load queue
    output logic       o_st_retire_en,
    output addr_t      o_st_retire_addr,
    output lsu_func_t  o_st_retire_func,
    output logic       o_st_retire_hit,
    output data_t      o_st_retire_data,

    // Cache fill port
    input  logic       i_fill_en,
    input  addr_t      i_fill_addr,
    input  dc_way_t    i_fill_way,
    input  data_t      i_fill_data,

    // Memory write port
    output logic       o_mem_wr_en,
    output addr_t      o_mem_addr,
    output data_t      o_mem_data,
    output lsu_func_t  o_mem_func,
    input  logic       i_mem_ready
);

    logic           alloc_en;
    addr_t          alloc_addr;
    data_t          alloc_data;
    rob_tag_t       alloc_tag;
    lsu_func_t      alloc_func;

    logic           dc_hit;
    dc_way_t        dc_way;
    data_t          dc_data;
    dc_index_t      dc_index;
    dc_tag_t        dc_tag;
    logic           dc_write_en;
    dc_array_addr_t dc_write_addr;
    data_t          dc_write_data;

    logic           miss_push;
    logic           mshq_full;

    lsu_store_id issue_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_issue_en     (i_issue_en),
        .i_issue_base   (i_issue_base),
        .i_issue_offset (i_issue_offset),
        .i_issue_data   (i_issue_data),
        .i_issue_tag    (i_issue_tag),
        .i_issue_func   (i_issue_func),
        .o_alloc_en     (alloc_en),
        .o_alloc_addr   (alloc_addr),
        .o_alloc_data   (alloc_data),
        .o_alloc_tag    (alloc_tag),
        .o_alloc_func   (alloc_func)
    );

    lsu_sq sq_i (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_alloc_en         (alloc_en),
        .i_alloc_addr       (alloc_addr),
        .i_alloc_data       (alloc_data),
        .i_alloc_tag        (alloc_tag),
        .i_alloc_func       (alloc_func),
        .i_rob_retire_en    (i_rob_retire_en),
        .i_rob_retire_tag   (i_rob_retire_tag),
        .i_dc_hit           (dc_hit),
        .i_dc_way           (dc_way),
        .i_dc_data          (dc_data),
        .i_mshq_full        (mshq_full),
        .o_sq_full          (o_sq_full),
        .o_rob_retire_stall (o_rob_retire_stall),
        .o_dc_index         (dc_index),
        .o_dc_tag           (dc_tag),
        .o_dc_write_en      (dc_write_en),
        .o_dc_write_addr    (dc_write_addr),
        .o_dc_write_data    (dc_write_data),
        .o_miss_push        (miss_push),
        .o_retire_addr      (o_st_retire_addr),
        .o_retire_func      (o_st_retire_func),
        .o_retire_hit       (o_st_retire_hit),
        .o_retire_en        (o_st_retire_en),
        .o_retire_data      (o_st_retire_data)
    );

    // Word offset of the lookup comes straight from the retiring address
    dc_store_array dc_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lookup_index (dc_index),
        .i_lookup_tag   (dc_tag),
        .i_lookup_word  (o_st_retire_addr[`DC_LINE_WIDTH-1:2]),
        .i_fill_en      (i_fill_en),
        .i_fill_addr    (i_fill_addr),
        .i_fill_way     (i_fill_way),
        .i_fill_data    (i_fill_data),
        .i_write_en     (dc_write_en),
        .i_write_addr   (dc_write_addr),
        .i_write_data   (dc_write_data),
        .o_hit          (dc_hit),
        .o_way          (dc_way),
        .o_data         (dc_data)
    );

    lsu_mshq mshq_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_push      (miss_push),
        .i_push_addr (o_st_retire_addr),
        .i_push_data (o_st_retire_data),
        .i_push_func (o_st_retire_func),
        .o_full      (mshq_full),
        .i_mem_ready (i_mem_ready),
        .o_mem_wr_en (o_mem_wr_en),
        .o_mem_addr  (o_mem_addr),
        .o_mem_data  (o_mem_data),
        .o_mem_func  (o_mem_func)
    );

endmodule

/* bench/lsu_store_path_props.sv */
// Concurrent assertions on the store queue
// Bound into every lsu_sq instance

`timescale 1ns/1ps

module lsu_store_path_props (
    input logic       clk,
    input logic       n_rst,
    input logic [7:0] retire_sel,
    input logic [7:0] slot_valid,
    input logic       alloc_en,
    input logic       retire_en
);

    // At most one live slot may match the retiring ROB tag
    a_sel_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(retire_sel))
        else $error("retire select has more than one slot");

    // A retiring store must own a live slot
    a_tag_present: assert property (@(posedge clk) disable iff (!n_rst)
        retire_en |-> (|retire_sel))
        else $error("retired tag not present in the store queue");

    // Allocation needs an empty slot
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        alloc_en |-> !(&slot_valid))
        else $error("allocation into a full store queue");

endmodule

bind lsu_sq lsu_store_path_props props_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .retire_sel (retire_sel),
    .slot_valid (slot_valid),
    .alloc_en   (i_alloc_en),
    .retire_en  (o_retire_en)
);

/* bench/lsu_store_path_tb.sv */
// Testbench for the store path
// Clock, reset, cache model, reference merge, compare tasks and the checking process

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_path_tb
    import lsu_pkg::*;
    import dc_pkg::*;
;

    localparam int TIMEOUT = 200;

    logic clk;
    logic n_rst;
    logic i_flush;
    logic i_issue_en;
    addr_t i_issue_base;
    addr_t i_issue_offset;
    data_t i_issue_data;
    rob_tag_t i_issue_tag;
    lsu_func_t i_issue_func;
    logic o_sq_full;
    logic i_rob_retire_en;
    rob_tag_t i_rob_retire_tag;
    logic o_rob_retire_stall;
    logic o_st_retire_en;
    addr_t o_st_retire_addr;
    lsu_func_t o_st_retire_func;
    logic o_st_retire_hit;
    data_t o_st_retire_data;
    logic i_fill_en;
    addr_t i_fill_addr;
    dc_way_t i_fill_way;
    data_t i_fill_data;
    logic o_mem_wr_en;
    addr_t o_mem_addr;
    data_t o_mem_data;
    lsu_func_t o_mem_func;
    logic i_mem_ready;

    integer seed = 32'he6f6;

    // Cache model with words indexed like the data array by set, way and word
    logic    m_valid [16][2];
    dc_tag_t m_tag   [16][2];
    data_t   m_word  [256];

    // Issued stores recorded by ROB tag
    addr_t     st_addr [64];
    data_t     st_data [64];
    lsu_func_t st_func [64];

    // Expected retire and memory traffic in order
    data_t     q_rd[$];
    addr_t     q_ra[$];
    lsu_func_t q_rf[$];
    logic      q_rh[$];
    data_t     q_md[$];
    addr_t     q_ma[$];
    lsu_func_t q_mf[$];
    rob_tag_t  tag_q[$];

    lsu_store_path dut_i (.*);

    always #5 clk = ~clk;

    // Only the low bytes of the store replace the old word
    function automatic data_t expected_word(lsu_func_t func, data_t old_w, data_t st_w);
        case (func)
            SB:      return {old_w[31:8], st_w[7:0]};
            SH:      return {old_w[31:16], st_w[15:0]};
            default: return st_w;
        endcase
    endfunction

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_data(string name, data_t act, data_t exp);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, act, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t act, addr_t exp);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, act, exp));
        end
    endtask

    task automatic check_func(string name, lsu_func_t act, lsu_func_t exp);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %s expected %s", $time, name,
                                      act.name(), exp.name()));
        end
    endtask

    task automatic check_flag(string name, logic act, logic exp);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, act, exp));
        end
    endtask

    // Compare retiring stores and accepted memory writes at each rising edge
    always @(posedge clk) begin
        if (n_rst) begin
            if (o_st_retire_en) begin
                if (q_rd.size() == 0) begin
                    stop_with_error("A store retired although none was expected");
                end
                check_data("o_st_retire_data", o_st_retire_data, q_rd.pop_front());
                check_addr("o_st_retire_addr", o_st_retire_addr, q_ra.pop_front());
                check_func("o_st_retire_func", o_st_retire_func, q_rf.pop_front());
                check_flag("o_st_retire_hit", o_st_retire_hit, q_rh.pop_front());
            end
            if (o_mem_wr_en && i_mem_ready) begin
                if (q_md.size() == 0) begin
                    stop_with_error("A memory write appeared although none was expected");
                end
                check_data("o_mem_data", o_mem_data, q_md.pop_front());
                check_addr("o_mem_addr", o_mem_addr, q_ma.pop_front());
                check_func("o_mem_func", o_mem_func, q_mf.pop_front());
            end
        end
    end

    function automatic int word_index(addr_t a, int way);
        return {a[8:5], way[0], a[4:2]};
    endfunction

    task automatic fill_word(addr_t a, int way, data_t d);
        @(negedge clk);
        i_fill_en   = 1'b1;
        i_fill_addr = a;
        i_fill_way  = dc_way_t'(way);
        i_fill_data = d;
        m_valid[a[8:5]][way] = 1'b1;
        m_tag[a[8:5]][way]   = a[31:9];
        m_word[word_index(a, way)] = d;
        @(negedge clk);
        i_fill_en = 1'b0;
    endtask

    task automatic issue_store(rob_tag_t tag, addr_t base, addr_t off, data_t d, lsu_func_t f);
        int n;
        n = 0;
        @(negedge clk);
        while (o_sq_full) begin
            n++;
            if (n > TIMEOUT) begin
                stop_with_error("Timed out waiting for the store queue to leave full");
            end
            @(negedge clk);
        end
        i_issue_en     = 1'b1;
        i_issue_base   = base;
        i_issue_offset = off;
        i_issue_data   = d;
        i_issue_tag    = tag;
        i_issue_func   = f;
        st_addr[tag] = base + off;
        st_data[tag] = d;
        st_func[tag] = f;
        @(negedge clk);
        i_issue_en = 1'b0;
    endtask

    // Computes the expected outcome from the model and raises the retire request
    task automatic start_retire(rob_tag_t tag);
        addr_t a;
        logic  hit;
        int    way;
        data_t exp;
        a   = st_addr[tag];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[a[8:5]][w] && m_tag[a[8:5]][w] == a[31:9]) begin
                hit = 1'b1;
                way = w;
            end
        end
        exp = expected_word(st_func[tag], hit ? m_word[word_index(a, way)] : '0, st_data[tag]);
        q_rd.push_back(exp);
        q_ra.push_back(a);
        q_rf.push_back(st_func[tag]);
        q_rh.push_back(hit);
        if (hit) begin
            m_word[word_index(a, way)] = exp;
        end else begin
            q_md.push_back(exp);
            q_ma.push_back(a);
            q_mf.push_back(st_func[tag]);
        end
        @(negedge clk);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
    endtask

    // The ROB holds its request until an edge passes without a stall
    task automatic finish_retire();
        int n;
        n = 0;
        @(posedge clk);
        while (o_rob_retire_stall) begin
            n++;
            if (n > TIMEOUT) begin
                stop_with_error("Timed out waiting for the retire stall to clear");
            end
            @(posedge clk);
        end
        @(negedge clk);
        i_rob_retire_en = 1'b0;
    endtask

    task automatic retire_store(rob_tag_t tag);
        start_retire(tag);
        finish_retire();
    endtask

    task automatic wait_mem_drain();
        int n;
        n = 0;
        while (q_md.size() != 0) begin
            n++;
            if (n > TIMEOUT) begin
                stop_with_error("Timed out waiting for the memory writes to complete");
            end
            @(posedge clk);
        end
    endtask

    task automatic shuffle_tag_q();
        int j;
        rob_tag_t t;
        for (int i = tag_q.size() - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            t = tag_q[i];
            tag_q[i] = tag_q[j];
            tag_q[j] = t;
        end
    endtask

    function automatic lsu_func_t rand_func();
        return lsu_func_t'($unsigned($random(seed)) % 3);
    endfunction

    initial begin
        addr_t    a1;
        addr_t    a2;
        addr_t    base;
        rob_tag_t t0;
        rob_tag_t t;
        clk = 1'b0;
        n_rst = 1'b0;
        i_flush = 1'b0;
        i_issue_en = 1'b0;
        i_issue_base = '0;
        i_issue_offset = '0;
        i_issue_data = '0;
        i_issue_tag = '0;
        i_issue_func = SB;
        i_rob_retire_en = 1'b0;
        i_rob_retire_tag = '0;
        i_fill_en = 1'b0;
        i_fill_addr = '0;
        i_fill_way = '0;
        i_fill_data = '0;
        i_mem_ready = 1'b1;
        for (int s = 0; s < 16; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        repeat (16) @(negedge clk);
        n_rst = 1'b1;

        // Control outputs after reset and a miss on an empty cache
        @(negedge clk);
        check_flag("o_mem_wr_en", o_mem_wr_en, 1'b0);
        check_flag("o_rob_retire_stall", o_rob_retire_stall, 1'b0);
        check_flag("o_st_retire_en", o_st_retire_en, 1'b0);
        check_flag("o_sq_full", o_sq_full, 1'b0);
        issue_store(6'd1, 32'h0000_4000, 32'h24, $random(seed), SW);
        retire_store(6'd1);
        wait_mem_drain();

        // Hits on filled lines in both ways of one set
        a1 = 32'h1234_5640;
        a2 = 32'h5678_9640;
        fill_word(a1, 0, $random(seed));
        fill_word(a1 + 4, 0, $random(seed));
        fill_word(a2, 1, $random(seed));
        base = $random(seed);
        issue_store(6'd2, base, a1 - base, $random(seed), SB);
        retire_store(6'd2);
        issue_store(6'd3, base, a2 - base, $random(seed), SH);
        retire_store(6'd3);
        issue_store(6'd4, base, a1 + 4 - base, $random(seed), SW);
        retire_store(6'd4);
        issue_store(6'd5, a1, 32'h0, $random(seed), SH);
        retire_store(6'd5);
        issue_store(6'd6, a1 - 32'h10, 32'h10, $random(seed), SB);
        retire_store(6'd6);

        // Misses under memory back-pressure fill the miss queue and stall
        @(negedge clk);
        i_mem_ready = 1'b0;
        issue_store(6'd7, 32'h8000_0000, 32'h104, $random(seed), SB);
        issue_store(6'd8, 32'h8000_1000, 32'h208, $random(seed), SH);
        issue_store(6'd9, 32'h8000_2000, 32'h30c, $random(seed), SW);
        retire_store(6'd7);
        retire_store(6'd8);
        start_retire(6'd9);
        repeat (3) begin
            @(posedge clk);
            check_flag("o_rob_retire_stall", o_rob_retire_stall, 1'b1);
            check_flag("o_mem_wr_en", o_mem_wr_en, 1'b1);
        end
        @(negedge clk);
        i_mem_ready = 1'b1;
        finish_retire();
        wait_mem_drain();

        // Fill the store queue and retire in random tag order
        t0 = $random(seed);
        tag_q.delete();
        for (int i = 0; i < 7; i++) begin
            t = t0 + rob_tag_t'(i * 7);
            tag_q.push_back(t);
            issue_store(t, $random(seed), $random(seed), $random(seed), rand_func());
            @(negedge clk);
            check_flag("o_sq_full", o_sq_full, (i + 1) >= 7);
        end
        shuffle_tag_q();
        retire_store(tag_q.pop_front());
        t = t0 + rob_tag_t'(49);
        tag_q.push_back(t);
        issue_store(t, $random(seed), $random(seed), $random(seed), rand_func());
        shuffle_tag_q();
        while (tag_q.size() != 0) begin
            retire_store(tag_q.pop_front());
        end
        wait_mem_drain();

        // A flush drops live stores while a queued memory write survives
        @(negedge clk);
        i_mem_ready = 1'b0;
        issue_store(6'd10, 32'h9000_0000, 32'h40, $random(seed), SW);
        retire_store(6'd10);
        issue_store(6'd11, 32'h0, a1, $random(seed), SW);
        @(negedge clk);
        // The flush spans the slot that holds store 11 and store 12 entering the issue stage
        i_flush = 1'b1;
        issue_store(6'd12, 32'h0, a2, $random(seed), SB);
        i_flush = 1'b0;
        @(negedge clk);
        check_flag("o_sq_full", o_sq_full, 1'b0);
        issue_store(6'd11, 32'h0, a1 + 4, $random(seed), SH);
        issue_store(6'd12, 32'h0, a2, $random(seed), SB);
        retire_store(6'd12);
        retire_store(6'd11);
        @(negedge clk);
        i_mem_ready = 1'b1;
        wait_mem_drain();
        repeat (4) @(negedge clk);

        if (q_rd.size() == 0 && q_md.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_error("Some expected retires or memory writes never appeared");
        end
    end

endmodule

/* src.f */
+incdir+hw
hw/lsu_pkg.sv
hw/dc_pkg.sv
hw/lsu_store_id.sv
hw/lsu_sq.sv
hw/dc_store_array.sv
hw/lsu_mshq.sv
hw/lsu_store_path.sv
bench/lsu_store_path_props.sv
bench/lsu_store_path_tb.sv

/* run.sh */
#!/bin/sh
# Builds the store path testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module lsu_store_path_tb -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" || { echo "FAIL"; exit 1; }
